/* build.f */
+incdir+include
design/afifo_pkg.sv
design/afifo_cell.sv
design/thresh_monitor.sv
design/afifo_chain.sv
test/tb_clock_gen.sv
test/afifo_chain_asserts.sv
test/afifo_chain_tb.sv

/* test/afifo_chain_tb.sv */
`timescale 1ns/1ps
`include "afifo_config.svh"

module afifo_chain_tb;
    import afifo_pkg::*;

    localparam int CELL_WORDS     = 1 << `AFC_DEPTH_LOG2;
    localparam int FILL_WORDS     = `AFC_CELLS * CELL_WORDS;
    localparam int STREAM_WORDS   = 200;
    localparam int RESET_CYCLES   = 16;
    localparam int SETTLE_CYCLES  = 20;
    localparam int TIMEOUT_CYCLES = 40 * (STREAM_WORDS + FILL_WORDS) + 500;
    localparam word_t IGNORED_WORD = word_t'('hdead);

    typedef struct packed {
        logic w_thresh;
        logic r_thresh;
    } flags_t;

    logic  w_clk;
    logic  prop_clk;
    logic  r_clk;
    logic  reset;
    push_t push;
    logic  w_ready;
    logic  w_thresh;
    logic  r_trigger;
    pop_t  pop;
    logic  r_thresh;

    word_t ref_q[$];  // accepted words not yet checked.
    word_t got_q[$];  // popped words waiting for the compare process.
    int    checks;
    int    value_errors;
    int    other_errors;
    int    cycles;

    tb_clock_gen #(.PERIOD_NS(100.0)) u_w_clk    (.clk(w_clk));
    tb_clock_gen #(.PERIOD_NS(100.0)) u_prop_clk (.clk(prop_clk));
    tb_clock_gen #(.PERIOD_NS(130.0)) u_r_clk    (.clk(r_clk));

    afifo_chain UUT (
        .w_clk     (w_clk),
        .prop_clk  (prop_clk),
        .r_clk     (r_clk),
        .reset     (reset),
        .push      (push),
        .w_ready   (w_ready),
        .w_thresh  (w_thresh),
        .r_trigger (r_trigger),
        .pop       (pop),
        .r_thresh  (r_thresh)
    );

    // ==============================
    // reference model
    // ==============================

    function automatic word_t ref_next_word();
        return ref_q.pop_front();  // oldest accepted word leaves first.
    endfunction

    // settled fill flags for a given number of held words.
    function automatic flags_t ref_flags(input int held);
        flags_t f;
        f.w_thresh = (held <= (`AFC_CELLS - `AFC_W_THRESH) * CELL_WORDS);
        f.r_thresh = (held >= `AFC_R_THRESH * CELL_WORDS);
        return f;
    endfunction

    // ==============================
    // compare tasks
    // ==============================

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ==============================
    // drivers
    // ==============================

    // leaves the trigger high for the edge that takes the word.
    task automatic send_word(input word_t d);
        @(negedge w_clk);
        push = '{trigger: 1'b1, data: d};
        while (w_ready !== 1'b1) begin
            @(negedge w_clk);
        end
        ref_q.push_back(d);
    endtask

    task automatic write_words(input int n, input bit use_gaps);
        int gap;
        int k;
        for (k = 0; k < n; k++) begin
            gap = use_gaps ? int'($urandom % 4) : 0;
            repeat (gap) begin
                @(negedge w_clk);
                push.trigger = 1'b0;
            end
            send_word(word_t'($urandom));
        end
        @(negedge w_clk);
        push.trigger = 1'b0;
    endtask

    task automatic read_words(input int n, input bit use_gaps);
        int taken;
        int gap;
        taken = 0;
        gap = 0;
        while (taken < n) begin
            @(negedge r_clk);
            if (gap > 0) begin
                r_trigger = 1'b0;
                gap--;
            end else begin
                r_trigger = 1'b1;
                if (pop.ready === 1'b1) begin  // pop happens at the next rising edge.
                    got_q.push_back(pop.data);
                    taken++;
                    gap = use_gaps ? int'($urandom % 4) : 0;
                end
            end
        end
        @(negedge r_clk);
        r_trigger = 1'b0;
    endtask

    task automatic check_settled_flags();
        flags_t exp;
        repeat (SETTLE_CYCLES) @(negedge w_clk);
        exp = ref_flags(ref_q.size());
        check_flag("w_thresh", w_thresh, exp.w_thresh);
        @(negedge r_clk);
        check_flag("r_thresh", r_thresh, exp.r_thresh);
    endtask

    task automatic check_model_empty(input string phase);
        wait (got_q.size() == 0);
        if (ref_q.size() != 0) begin
            other_errors++;
            $display("%s left %0d accepted words that never came out", phase, ref_q.size());
        end
    endtask

    // ==============================
    // compare process
    // ==============================

    initial begin : compare
        word_t got;
        word_t exp;
        forever begin
            wait (got_q.size() != 0);
            got = got_q.pop_front();
            if (ref_q.size() == 0) begin
                other_errors++;
                $display("popped word %h although no word was written", got);
            end else begin
                exp = ref_next_word();
                check_word("pop.data", got, exp);
            end
        end
    end

    initial begin : timeout
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge w_clk);
            cycles++;
        end
        $display("run stopped after %0d w_clk cycles without finishing", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin : main
        int total;
        void'($urandom(32'ha2a5_b0ee));
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        reset = 1'b1;
        push = '0;
        r_trigger = 1'b0;
        repeat (RESET_CYCLES) @(negedge w_clk);
        reset = 1'b0;

        // reset state
        @(negedge w_clk);
        check_flag("w_ready", w_ready, 1'b1);
        check_flag("pop.ready", pop.ready, 1'b0);
        @(negedge w_clk);
        check_flag("w_thresh", w_thresh, 1'b1);  // two edges through the sync.
        @(negedge r_clk);
        check_flag("r_thresh", r_thresh, 1'b0);

        // random stream with gaps on both sides
        fork
            write_words(STREAM_WORDS, 1'b1);
            read_words(STREAM_WORDS, 1'b1);
        join
        check_model_empty("stream");

        // fill with the read side stalled
        write_words(FILL_WORDS, 1'b0);
        repeat (SETTLE_CYCLES) begin
            @(negedge w_clk);
            push = '{trigger: 1'b1, data: IGNORED_WORD};  // must not be taken.
            check_flag("w_ready", w_ready, 1'b0);
        end
        @(negedge w_clk);
        push.trigger = 1'b0;
        check_settled_flags();

        // drain, then poke the empty read port
        read_words(FILL_WORDS, 1'b1);
        check_model_empty("drain");
        repeat (SETTLE_CYCLES) begin
            @(negedge r_clk);
            r_trigger = 1'b1;
            check_flag("pop.ready", pop.ready, 1'b0);
        end
        @(negedge r_clk);
        r_trigger = 1'b0;
        check_settled_flags();

        total = value_errors + other_errors + int'(UUT.u_asserts.fail_count);
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, UUT.u_asserts.fail_count);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* test/afifo_chain_asserts.sv */
`timescale 1ns/1ps

module afifo_chain_asserts (
    input logic             w_clk,
    input logic             r_clk,
    input logic             reset,
    input logic             w_ready,
    input logic             r_trigger,
    input afifo_pkg::pop_t  pop
);

    int unsigned fail_count = 0;  // assertion failures so far.

    // ==============================
    // read port
    // ==============================

    // head word may only move on a pop.
    a_head_stable: assert property (@(posedge r_clk) disable iff (reset)
        (pop.ready && !r_trigger) |=> $stable(pop.data))
    else begin
        fail_count++;
        $error("pop.data changed while the head word was held");
    end

    a_head_known: assert property (@(posedge r_clk) disable iff (reset)
        pop.ready |-> !$isunknown(pop.data))
    else begin
        fail_count++;
        $error("pop.data has unknown bits while pop.ready is high");
    end

    // ==============================
    // reset exit
    // ==============================

    a_reset_exit: assert property (@(posedge w_clk)
        $fell(reset) |-> (w_ready && !pop.ready))
    else begin
        fail_count++;
        $error("chain not empty and writable in the first cycle after reset");
    end

endmodule

bind afifo_chain afifo_chain_asserts u_asserts (
    .w_clk     (w_clk),
    .r_clk     (r_clk),
    .reset     (reset),
    .w_ready   (w_ready),
    .r_trigger (r_trigger),
    .pop       (pop)
);

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0  // full clock period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;  // half period per level.
        end
    end

endmodule

/* design/afifo_chain.sv */
`timescale 1ns/1ps
`include "afifo_config.svh"

module afifo_chain (
    input  logic              w_clk,
    input  logic              prop_clk,   // clock for the cell-to-cell hops.
    input  logic              r_clk,
    input  logic              reset,
    // write port
    input  afifo_pkg::push_t  push,
    output logic              w_ready,
    output logic              w_thresh,   // at least AFC_W_THRESH cells empty.
    // read port
    input  logic              r_trigger,
    output afifo_pkg::pop_t   pop,
    output logic              r_thresh    // at least AFC_R_THRESH cells full.
);
    import afifo_pkg::*;

    localparam int LAST         = `AFC_CELLS - 1;
    localparam int W_THRESH_IDX = `AFC_W_THRESH - 1;
    localparam int R_THRESH_IDX = `AFC_CELLS - `AFC_R_THRESH;

    push_t                 cell_push      [`AFC_CELLS];
    pop_t                  cell_pop       [`AFC_CELLS];
    logic [`AFC_CELLS-1:0] cell_w_ready;
    logic [`AFC_CELLS-1:0] cell_pop_ready;
    logic [`AFC_CELLS-1:0] cell_r_trigger;

    // ==============================
    // cell chain
    // ==============================

    for (genvar i = 0; i < `AFC_CELLS; i++) begin : g_cell
        logic cw_clk;  // write clock of this cell.
        logic cr_clk;  // read clock of this cell.

        // input side takes words from the write port.
        if (i == 0) begin : g_head
            assign cw_clk       = w_clk;
            assign cell_push[i] = push;
        end else begin : g_link_in
            assign cw_clk       = prop_clk;
            assign cell_push[i] = '{trigger: cell_pop[i-1].ready,
                                    data:    cell_pop[i-1].data};
        end

        // output side hands words to the read port.
        if (i == LAST) begin : g_tail
            assign cr_clk            = r_clk;
            assign cell_r_trigger[i] = r_trigger;
        end else begin : g_link_out
            assign cr_clk            = prop_clk;
            assign cell_r_trigger[i] = cell_w_ready[i+1];  // next cell has room.
        end

        assign cell_pop_ready[i] = cell_pop[i].ready;

        afifo_cell u_cell (
            .w_clk     (cw_clk),
            .r_clk     (cr_clk),
            .reset     (reset),
            .push      (cell_push[i]),
            .w_ready   (cell_w_ready[i]),
            .r_trigger (cell_r_trigger[i]),
            .pop       (cell_pop[i])
        );
    end

    assign w_ready = cell_w_ready[0];
    assign pop     = cell_pop[LAST];

    // ==============================
    // fill flags
    // ==============================

    // empty cell means no valid head word.
    thresh_monitor #(
        .THRESH_IDX (W_THRESH_IDX)
    ) u_w_thresh (
        .clk        (w_clk),
        .reset      (reset),
        .cell_ready (cell_pop_ready),
        .flag       (w_thresh)
    );

    // full cell means no room for a write.
    thresh_monitor #(
        .THRESH_IDX (R_THRESH_IDX)
    ) u_r_thresh (
        .clk        (r_clk),
        .reset      (reset),
        .cell_ready (cell_w_ready),
        .flag       (r_thresh)
    );

endmodule

/* design/thresh_monitor.sv */
`timescale 1ns/1ps
`include "afifo_config.svh"

module thresh_monitor #(
    parameter int THRESH_IDX = 0  // cell whose ready bit is watched.
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`AFC_CELLS-1:0] cell_ready,
    output logic                  flag
);

    // ==============================
    // index check
    // ==============================

    if (THRESH_IDX < 0 || THRESH_IDX >= `AFC_CELLS) begin : g_bad_idx
        $error("thresh_monitor index %0d outside the chain", THRESH_IDX);
    end

    // ==============================
    // crossing into clk
    // ==============================

    logic raw_flag;   // watched bit, still in its own domain.
    logic flag_meta;  // first stage, may be metastable.
    logic flag_sync;  // second stage.

    // a cell that is not ready means the watched condition holds.
    assign raw_flag = ~cell_ready[THRESH_IDX];

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_meta <= 1'b0;
            flag_sync <= 1'b0;
        end else begin
            flag_meta <= raw_flag;
            flag_sync <= flag_meta;
        end
    end

    assign flag = flag_sync;  // settles two clk edges after a change.

endmodule

/* design/afifo_cell.sv */
`timescale 1ns/1ps
`include "afifo_config.svh"

module afifo_cell (
    input  logic              w_clk,
    input  logic              r_clk,
    input  logic              reset,
    input  afifo_pkg::push_t  push,
    output logic              w_ready,
    input  logic              r_trigger,
    output afifo_pkg::pop_t   pop
);
    import afifo_pkg::*;

    localparam int AW    = `AFC_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    // full when the pointers differ only in the two top gray bits.
    localparam logic [AW:0] FULL_MASK = (AW+1)'(2'b11) << (AW - 1);

    function automatic logic [AW:0] to_gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    word_t mem [DEPTH];  // storage written on w_clk and read on r_clk.

    logic [AW:0] r_gray;      // read pointer as seen by the write side.

    // ==============================
    // write domain
    // ==============================

    logic [AW:0] w_bin;       // write pointer with one extra wrap bit.
    logic [AW:0] w_bin_next;
    logic [AW:0] w_gray;      // write pointer as seen by the read side.
    logic [AW:0] rg_meta;     // first sync stage of the read pointer.
    logic [AW:0] rg_sync;     // read pointer settled in the w_clk domain.
    logic        full;
    logic        w_fire;

    assign full       = (w_gray == (rg_sync ^ FULL_MASK));
    assign w_ready    = ~full;
    assign w_fire     = push.trigger & ~full;  // push while full is dropped.
    assign w_bin_next = w_bin + 1'b1;

    always_ff @(posedge w_clk) begin
        if (reset) begin
            w_bin   <= '0;
            w_gray  <= '0;
            rg_meta <= '0;
            rg_sync <= '0;
        end else begin
            rg_meta <= r_gray;
            rg_sync <= rg_meta;
            if (w_fire) begin
                w_bin  <= w_bin_next;
                w_gray <= to_gray(w_bin_next);
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_fire) begin
            mem[w_bin[AW-1:0]] <= push.data;
        end
    end

    // ==============================
    // read domain
    // ==============================

    logic [AW:0] r_bin;       // read pointer with one extra wrap bit.
    logic [AW:0] r_bin_next;
    logic [AW:0] wg_meta;     // first sync stage of the write pointer.
    logic [AW:0] wg_sync;     // write pointer settled in the r_clk domain.
    logic        empty;
    logic        r_fire;

    assign empty      = (r_gray == wg_sync);
    assign r_fire     = r_trigger & ~empty;  // pop while empty is dropped.
    assign r_bin_next = r_bin + 1'b1;

    // head word stays put until the next pop.
    assign pop = '{ready: ~empty, data: mem[r_bin[AW-1:0]]};

    always_ff @(posedge r_clk) begin
        if (reset) begin
            r_bin   <= '0;
            r_gray  <= '0;
            wg_meta <= '0;
            wg_sync <= '0;
        end else begin
            wg_meta <= w_gray;
            wg_sync <= wg_meta;
            if (r_fire) begin
                r_bin  <= r_bin_next;
                r_gray <= to_gray(r_bin_next);
            end
        end
    end

endmodule

/* design/afifo_pkg.sv */
`include "afifo_config.svh"

package afifo_pkg;

    // ==============================
    // data word
    // ==============================

    typedef logic [`AFC_WORD_W-1:0] word_t;

    // ==============================
    // handshake bundles
    // ==============================

    // write request into a cell or into the whole chain.
    typedef struct packed {
        logic  trigger;  // take data at this edge if ready.
        word_t data;     // word to store.
    } push_t;

    // head of a cell, seen from its read side.
    typedef struct packed {
        logic  ready;    // data holds the oldest word.
        word_t data;     // oldest word, show-ahead.
    } pop_t;

endpackage

/* include/afifo_config.svh */
`ifndef AFIFO_CONFIG_SVH
`define AFIFO_CONFIG_SVH

// ==============================
// word and cell geometry
// ==============================

// bits per data word.
`define AFC_WORD_W 16

// log2 of the words held by one cell.
`define AFC_DEPTH_LOG2 2

// number of cells chained between the write and read ports.
`define AFC_CELLS 3

// ==============================
// fill flags
// ==============================

// w_thresh is high while at least this many cells are empty.
`define AFC_W_THRESH 2

// r_thresh is high while at least this many cells are full.
`define AFC_R_THRESH 2

`endif
